// ==== mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// axi-lite bus widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32
`define MEM_STRB_W 4

// word index into the storage array, 2**MEM_IDX_W words
`define MEM_IDX_W 10

// read data presented before the first array read (nop)
`define MEM_RESET_DATA 32'h00000013

`endif

// ==== mem_pkg.sv ====
`default_nettype none

`include "mem_config.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_W-1:0] axi_addr_t;   // byte address
    typedef logic [`MEM_DATA_W-1:0] axi_data_t;
    typedef logic [`MEM_STRB_W-1:0] axi_strb_t;
    typedef logic [1:0]             axi_resp_t;
    typedef logic [`MEM_IDX_W-1:0]  mem_idx_t;    // word index, addr[IDX_W+1:2]
    typedef logic [2:0]             wait_t;

    typedef enum logic [1:0] {
        SRAM_IDLE,
        SRAM_READ,
        SRAM_WADDR,   // address taken, waiting on W
        SRAM_WRITE
    } sram_state_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_FETCH,
        ARB_DATA
    } arb_state_t;

endpackage

`default_nettype wire

// ==== sram_array.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module sram_array (
    input  wire                clk,
    input  wire mem_pkg::mem_idx_t  mem_idx,
    input  wire                mem_re,
    input  wire                mem_we,
    input  wire mem_pkg::axi_strb_t mem_wstrb,
    input  wire mem_pkg::axi_data_t mem_wdata,
    output mem_pkg::axi_data_t      mem_rdata
);

    mem_pkg::axi_data_t mem [0:(2**`MEM_IDX_W)-1];

    // byte lane writes
    always_ff @(posedge clk) begin
        if (mem_we) begin
            for (int i = 0; i < `MEM_STRB_W; i++) begin
                if (mem_wstrb[i]) begin
                    mem[mem_idx][i*8 +: 8] <= mem_wdata[i*8 +: 8];
                end
            end
        end
    end

    // registered read, holds until the next mem_re
    always_ff @(posedge clk) begin
        if (mem_re) begin
            mem_rdata <= mem[mem_idx];
        end
    end

endmodule

`default_nettype wire

// ==== sram_latency_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_latency_ctrl (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 cfg_we,
    input  wire                 cfg_random,
    input  wire mem_pkg::wait_t cfg_wait,
    input  wire                 sram_idle,
    output mem_pkg::wait_t      wait_target
);

    logic           random_q;   // 1: lfsr drives the wait count
    mem_pkg::wait_t wait_q;
    mem_pkg::wait_t lfsr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            random_q <= 1'b0;
            wait_q   <= '0;
        end else if (cfg_we) begin
            random_q <= cfg_random;
            wait_q   <= cfg_wait;
        end
    end

    // x^3 + x^2 + 1, never reaches zero from a nonzero seed
    // frozen during a transaction so the target holds while counted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= 3'b001;
        end else if (sram_idle) begin
            lfsr <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
        end
    end

    assign wait_target = random_q ? lfsr : wait_q;

endmodule

`default_nettype wire

// ==== sram_axil.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module sram_axil (
    input  wire                     clk,
    input  wire                     rst_n,
    // ar
    input  wire mem_pkg::axi_addr_t s_araddr,
    input  wire                     s_arvalid,
    output logic                    s_arready,
    // r
    output mem_pkg::axi_data_t      s_rdata,
    output mem_pkg::axi_resp_t      s_rresp,
    output logic                    s_rvalid,
    input  wire                     s_rready,
    // aw
    input  wire mem_pkg::axi_addr_t s_awaddr,
    input  wire                     s_awvalid,
    output logic                    s_awready,
    // w
    input  wire mem_pkg::axi_data_t s_wdata,
    input  wire mem_pkg::axi_strb_t s_wstrb,
    input  wire                     s_wvalid,
    output logic                    s_wready,
    // b
    output mem_pkg::axi_resp_t      s_bresp,
    output logic                    s_bvalid,
    input  wire                     s_bready,
    // latency control
    input  wire mem_pkg::wait_t     wait_target,
    output logic                    sram_idle,
    // storage array
    output mem_pkg::mem_idx_t       mem_idx,
    output logic                    mem_re,
    output logic                    mem_we,
    output mem_pkg::axi_strb_t      mem_wstrb,
    output mem_pkg::axi_data_t      mem_wdata,
    input  wire mem_pkg::axi_data_t mem_rdata
);

    mem_pkg::sram_state_t state;
    mem_pkg::wait_t       wait_cnt;
    mem_pkg::axi_addr_t   addr_q;
    mem_pkg::axi_data_t   wdata_q;
    mem_pkg::axi_strb_t   wstrb_q;
    logic                 rvalid_q;
    logic                 bvalid_q;
    logic                 rd_loaded;   // array has been read at least once
    logic                 hit;

    assign hit = (wait_cnt == wait_target);

    assign sram_idle = (state == mem_pkg::SRAM_IDLE);
    assign s_arready = sram_idle;
    assign s_awready = sram_idle && !s_arvalid;   // ar wins a tie
    assign s_wready  = (state == mem_pkg::SRAM_WADDR);

    assign s_rvalid = rvalid_q;
    assign s_bvalid = bvalid_q;
    assign s_rresp  = 2'b00;   // okay
    assign s_bresp  = 2'b00;

    // array output register doubles as the rdata holding register
    assign s_rdata = rd_loaded ? mem_rdata : `MEM_RESET_DATA;

    assign mem_idx   = addr_q[`MEM_IDX_W+1:2];   // wraps within the array
    assign mem_wdata = wdata_q;
    assign mem_wstrb = wstrb_q;
    assign mem_re    = (state == mem_pkg::SRAM_READ) && !rvalid_q && hit;
    assign mem_we    = (state == mem_pkg::SRAM_WRITE) && !bvalid_q && hit;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= mem_pkg::SRAM_IDLE;
            wait_cnt  <= '0;
            rvalid_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            rd_loaded <= 1'b0;
        end else begin
            case (state)
                mem_pkg::SRAM_IDLE: begin
                    wait_cnt <= '0;
                    if (s_arvalid) begin
                        state <= mem_pkg::SRAM_READ;
                    end else if (s_awvalid) begin
                        state <= mem_pkg::SRAM_WADDR;
                    end
                end
                mem_pkg::SRAM_READ: begin
                    if (rvalid_q) begin
                        if (s_rready) begin
                            rvalid_q <= 1'b0;
                            state    <= mem_pkg::SRAM_IDLE;
                        end
                    end else if (hit) begin
                        rvalid_q  <= 1'b1;   // array captures on this edge
                        rd_loaded <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 3'd1;
                    end
                end
                mem_pkg::SRAM_WADDR: begin
                    if (s_wvalid) begin
                        wait_cnt <= '0;
                        state    <= mem_pkg::SRAM_WRITE;
                    end
                end
                mem_pkg::SRAM_WRITE: begin
                    if (bvalid_q) begin
                        if (s_bready) begin
                            bvalid_q <= 1'b0;
                            state    <= mem_pkg::SRAM_IDLE;
                        end
                    end else if (hit) begin
                        bvalid_q <= 1'b1;
                    end else begin
                        wait_cnt <= wait_cnt + 3'd1;
                    end
                end
                default: state <= mem_pkg::SRAM_IDLE;
            endcase
        end
    end

    // address and write payload
    always_ff @(posedge clk) begin
        if (state == mem_pkg::SRAM_IDLE) begin
            if (s_arvalid) begin
                addr_q <= s_araddr;
            end else if (s_awvalid) begin
                addr_q <= s_awaddr;
            end
        end
        if (s_wvalid && s_wready) begin
            wdata_q <= s_wdata;
            wstrb_q <= s_wstrb;
        end
    end

endmodule

`default_nettype wire

// ==== axil_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module axil_arbiter (
    input  wire                     clk,
    input  wire                     rst_n,
    // fetch master, read only
    input  wire mem_pkg::axi_addr_t f_araddr,
    input  wire                     f_arvalid,
    output logic                    f_arready,
    output mem_pkg::axi_data_t      f_rdata,
    output mem_pkg::axi_resp_t      f_rresp,
    output logic                    f_rvalid,
    input  wire                     f_rready,
    // data master
    input  wire mem_pkg::axi_addr_t d_araddr,
    input  wire                     d_arvalid,
    output logic                    d_arready,
    output mem_pkg::axi_data_t      d_rdata,
    output mem_pkg::axi_resp_t      d_rresp,
    output logic                    d_rvalid,
    input  wire                     d_rready,
    input  wire mem_pkg::axi_addr_t d_awaddr,
    input  wire                     d_awvalid,
    output logic                    d_awready,
    input  wire mem_pkg::axi_data_t d_wdata,
    input  wire mem_pkg::axi_strb_t d_wstrb,
    input  wire                     d_wvalid,
    output logic                    d_wready,
    output mem_pkg::axi_resp_t      d_bresp,
    output logic                    d_bvalid,
    input  wire                     d_bready,
    // shared slave
    output mem_pkg::axi_addr_t      s_araddr,
    output logic                    s_arvalid,
    input  wire                     s_arready,
    input  wire mem_pkg::axi_data_t s_rdata,
    input  wire mem_pkg::axi_resp_t s_rresp,
    input  wire                     s_rvalid,
    output logic                    s_rready,
    output mem_pkg::axi_addr_t      s_awaddr,
    output logic                    s_awvalid,
    input  wire                     s_awready,
    output mem_pkg::axi_data_t      s_wdata,
    output mem_pkg::axi_strb_t      s_wstrb,
    output logic                    s_wvalid,
    input  wire                     s_wready,
    input  wire mem_pkg::axi_resp_t s_bresp,
    input  wire                     s_bvalid,
    output logic                    s_bready
);

    mem_pkg::arb_state_t state;
    logic                last_data;   // data master got the previous grant
    logic                f_req;
    logic                d_req;
    logic                f_gnt;
    logic                d_gnt;

    assign f_req = f_arvalid;
    assign d_req = d_arvalid || d_awvalid;
    assign f_gnt = (state == mem_pkg::ARB_FETCH);
    assign d_gnt = (state == mem_pkg::ARB_DATA);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= mem_pkg::ARB_IDLE;
            last_data <= 1'b0;
        end else begin
            case (state)
                mem_pkg::ARB_IDLE: begin
                    if (f_req && (!d_req || last_data)) begin
                        state     <= mem_pkg::ARB_FETCH;
                        last_data <= 1'b0;
                    end else if (d_req) begin
                        state     <= mem_pkg::ARB_DATA;
                        last_data <= 1'b1;
                    end
                end
                mem_pkg::ARB_FETCH: begin
                    if (s_rvalid && s_rready) state <= mem_pkg::ARB_IDLE;
                end
                mem_pkg::ARB_DATA: begin
                    if ((s_rvalid && s_rready) || (s_bvalid && s_bready)) begin
                        state <= mem_pkg::ARB_IDLE;
                    end
                end
                default: state <= mem_pkg::ARB_IDLE;
            endcase
        end
    end

    // requests toward the slave
    assign s_araddr  = f_gnt ? f_araddr : d_araddr;
    assign s_arvalid = (f_gnt && f_arvalid) || (d_gnt && d_arvalid);
    assign s_rready  = (f_gnt && f_rready) || (d_gnt && d_rready);
    assign s_awaddr  = d_awaddr;
    assign s_awvalid = d_gnt && d_awvalid;
    assign s_wdata   = d_wdata;
    assign s_wstrb   = d_wstrb;
    assign s_wvalid  = d_gnt && d_wvalid;
    assign s_bready  = d_gnt && d_bready;

    // responses, only the granted side sees ready/valid
    assign f_arready = f_gnt && s_arready;
    assign f_rvalid  = f_gnt && s_rvalid;
    assign f_rdata   = s_rdata;
    assign f_rresp   = s_rresp;

    assign d_arready = d_gnt && s_arready;
    assign d_rvalid  = d_gnt && s_rvalid;
    assign d_rdata   = s_rdata;
    assign d_rresp   = s_rresp;
    assign d_awready = d_gnt && s_awready;
    assign d_wready  = d_gnt && s_wready;
    assign d_bvalid  = d_gnt && s_bvalid;
    assign d_bresp   = s_bresp;

endmodule

`default_nettype wire

// ==== mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsys (
    input  wire                     clk,
    input  wire                     rst_n,
    // fetch master
    input  wire mem_pkg::axi_addr_t f_araddr,
    input  wire                     f_arvalid,
    output mem_pkg::axi_data_t      f_rdata,
    output mem_pkg::axi_resp_t      f_rresp,
    output logic                    f_arready,
    output logic                    f_rvalid,
    input  wire                     f_rready,
    // data master
    input  wire mem_pkg::axi_addr_t d_araddr,
    input  wire                     d_arvalid,
    output logic                    d_arready,
    output mem_pkg::axi_data_t      d_rdata,
    output mem_pkg::axi_resp_t      d_rresp,
    output logic                    d_rvalid,
    input  wire                     d_rready,
    input  wire mem_pkg::axi_addr_t d_awaddr,
    input  wire                     d_awvalid,
    output logic                    d_awready,
    input  wire mem_pkg::axi_data_t d_wdata,
    input  wire mem_pkg::axi_strb_t d_wstrb,
    input  wire                     d_wvalid,
    output logic                    d_wready,
    output mem_pkg::axi_resp_t      d_bresp,
    output logic                    d_bvalid,
    input  wire                     d_bready,
    // latency configuration
    input  wire                     cfg_we,
    input  wire                     cfg_random,
    input  wire mem_pkg::wait_t     cfg_wait
);

    // arbiter to slave
    mem_pkg::axi_addr_t s_araddr;
    mem_pkg::axi_addr_t s_awaddr;
    mem_pkg::axi_data_t s_rdata;
    mem_pkg::axi_data_t s_wdata;
    mem_pkg::axi_strb_t s_wstrb;
    mem_pkg::axi_resp_t s_rresp;
    mem_pkg::axi_resp_t s_bresp;
    logic               s_arvalid;
    logic               s_arready;
    logic               s_rvalid;
    logic               s_rready;
    logic               s_awvalid;
    logic               s_awready;
    logic               s_wvalid;
    logic               s_wready;
    logic               s_bvalid;
    logic               s_bready;

    // slave to array and latency control
    mem_pkg::mem_idx_t  mem_idx;
    mem_pkg::axi_data_t mem_wdata;
    mem_pkg::axi_data_t mem_rdata;
    mem_pkg::axi_strb_t mem_wstrb;
    logic               mem_re;
    logic               mem_we;
    mem_pkg::wait_t     wait_target;
    logic               sram_idle;

    axil_arbiter arbiter_i (.*);

    sram_axil sram_i (.*);

    sram_array array_i (.*);

    sram_latency_ctrl latency_i (.*);

endmodule

`default_nettype wire

// ==== tb_mem_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_config.svh"

module tb_mem_subsys;

    localparam int PERIOD    = 40;
    localparam int RESET_CYC = 16;
    localparam int MAX_STALL = 3;               // longest run of ready low
    localparam int MAX_BP    = 7 + MAX_STALL;   // worst wait plus stall

    typedef enum {OP_CFG, OP_FRD, OP_DRD, OP_DWR, OP_BOTH} op_t;

    typedef struct {
        op_t                op;
        mem_pkg::axi_addr_t addr;
        mem_pkg::axi_addr_t addr2;     // data side of OP_BOTH
        mem_pkg::axi_data_t data;
        mem_pkg::axi_strb_t strb;
        logic               rnd;
        mem_pkg::wait_t     wt;
        int                 exp_lat;   // -1 skips the latency check
        string              name;
    } entry_t;

    logic               clk;
    logic               rst_n;
    mem_pkg::axi_addr_t f_araddr;
    logic               f_arvalid;
    logic               f_arready;
    mem_pkg::axi_data_t f_rdata;
    mem_pkg::axi_resp_t f_rresp;
    logic               f_rvalid;
    logic               f_rready;
    mem_pkg::axi_addr_t d_araddr;
    logic               d_arvalid;
    logic               d_arready;
    mem_pkg::axi_data_t d_rdata;
    mem_pkg::axi_resp_t d_rresp;
    logic               d_rvalid;
    logic               d_rready;
    mem_pkg::axi_addr_t d_awaddr;
    logic               d_awvalid;
    logic               d_awready;
    mem_pkg::axi_data_t d_wdata;
    mem_pkg::axi_strb_t d_wstrb;
    logic               d_wvalid;
    logic               d_wready;
    mem_pkg::axi_resp_t d_bresp;
    logic               d_bvalid;
    logic               d_bready;
    logic               cfg_we;
    logic               cfg_random;
    mem_pkg::wait_t     cfg_wait;

    entry_t             tbl[$];
    int                 n_tests = 0;
    logic [31:0]        lcg_state = 32'hac10a041;
    logic               cur_random = 1'b0;
    logic               last_data = 1'b0;   // data master served last
    mem_pkg::axi_data_t ref_mem [0:(2**`MEM_IDX_W)-1];

    mem_subsys dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ready stays low for at most MAX_STALL cycles in a row
    function automatic logic next_ready(inout int stall);
        logic [31:0] r;
        r = lcg_next();
        if (stall < MAX_STALL && r[16]) begin
            stall++;
            return 1'b0;
        end
        stall = 0;
        return 1'b1;
    endfunction

    function automatic int ref_idx(input mem_pkg::axi_addr_t addr);
        return (addr >> 2) % (2**`MEM_IDX_W);
    endfunction

    task automatic ref_write(input mem_pkg::axi_addr_t addr, input mem_pkg::axi_data_t data,
                             input mem_pkg::axi_strb_t strb);
        for (int i = 0; i < `MEM_STRB_W; i++) begin
            if (strb[i]) ref_mem[ref_idx(addr)][i*8 +: 8] = data[i*8 +: 8];
        end
    endtask

    task automatic check_data(input string name, input mem_pkg::axi_data_t exp,
                              input mem_pkg::axi_data_t act);
        if (act !== exp) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_resp(input string name, input mem_pkg::axi_resp_t exp,
                              input mem_pkg::axi_resp_t act);
        if (act !== exp) begin
            $display("Error %s: expected resp %b, actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "resp mismatch");
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act,
                                 input logic at_most);
        if (at_most ? (act > exp) : (act != exp)) begin
            $display("Error %s: expected latency %s%0d, actual %0d", name,
                     at_most ? "at most " : "", exp, act);
            $display("TEST FAILED");
            $fatal(1, "latency mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Error %s: expected %b, actual %b", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    // lat counts cycles from the first arvalid sample
    task automatic axi_read(input bit fetch, input mem_pkg::axi_addr_t addr,
                            output mem_pkg::axi_data_t data, output mem_pkg::axi_resp_t resp,
                            output int lat, output time rise);
        int   n;
        int   stall;
        bit   seen;
        bit   done;
        bit   ar_go;
        bit   r_go;
        logic rv;
        n     = 0;
        stall = 0;
        seen  = 1'b0;
        done  = 1'b0;
        @(posedge clk);
        if (fetch) begin
            f_araddr  <= addr;
            f_arvalid <= 1'b1;
        end else begin
            d_araddr  <= addr;
            d_arvalid <= 1'b1;
        end
        while (!done) begin
            @(negedge clk);
            n++;
            ar_go = fetch ? (f_arvalid && f_arready) : (d_arvalid && d_arready);
            rv    = fetch ? f_rvalid : d_rvalid;
            r_go  = rv && (fetch ? f_rready : d_rready);
            if (rv && !seen) begin
                seen = 1'b1;
                lat  = n - 2;
                rise = $time;
            end
            if (r_go) begin
                data = fetch ? f_rdata : d_rdata;
                resp = fetch ? f_rresp : d_rresp;
            end
            @(posedge clk);
            if (fetch) begin
                if (ar_go) f_arvalid <= 1'b0;
                f_rready <= r_go ? 1'b0 : next_ready(stall);
            end else begin
                if (ar_go) d_arvalid <= 1'b0;
                d_rready <= r_go ? 1'b0 : next_ready(stall);
            end
            done = r_go;
        end
    endtask

    task automatic data_write(input mem_pkg::axi_addr_t addr, input mem_pkg::axi_data_t data,
                              input mem_pkg::axi_strb_t strb, output mem_pkg::axi_resp_t resp);
        int stall;
        bit done;
        bit aw_go;
        bit w_go;
        bit b_go;
        stall = 0;
        done  = 1'b0;
        @(posedge clk);
        d_awaddr  <= addr;
        d_awvalid <= 1'b1;
        d_wdata   <= data;
        d_wstrb   <= strb;
        d_wvalid  <= 1'b1;
        while (!done) begin
            @(negedge clk);
            aw_go = d_awvalid && d_awready;
            w_go  = d_wvalid && d_wready;
            b_go  = d_bvalid && d_bready;
            if (b_go) resp = d_bresp;
            @(posedge clk);
            if (aw_go) d_awvalid <= 1'b0;
            if (w_go) d_wvalid <= 1'b0;
            d_bready <= b_go ? 1'b0 : next_ready(stall);
            done = b_go;
        end
    endtask

    task automatic run_entry(input entry_t e);
        mem_pkg::axi_data_t f_data;
        mem_pkg::axi_data_t d_data;
        mem_pkg::axi_resp_t f_resp;
        mem_pkg::axi_resp_t d_resp;
        int                 f_lat;
        int                 d_lat;
        time                f_rise;
        time                d_rise;
        case (e.op)
            OP_CFG: begin
                @(posedge clk);
                cfg_we     <= 1'b1;
                cfg_random <= e.rnd;
                cfg_wait   <= e.wt;
                @(posedge clk);
                cfg_we     <= 1'b0;
                cur_random = e.rnd;
            end
            OP_DWR: begin
                data_write(e.addr, e.data, e.strb, d_resp);
                check_resp(e.name, 2'b00, d_resp);
                ref_write(e.addr, e.data, e.strb);
                last_data = 1'b1;
            end
            OP_FRD, OP_DRD: begin
                axi_read(e.op == OP_FRD, e.addr, d_data, d_resp, d_lat, d_rise);
                check_data(e.name, ref_mem[ref_idx(e.addr)], d_data);
                check_resp(e.name, 2'b00, d_resp);
                if (e.exp_lat >= 0) check_latency(e.name, e.exp_lat, d_lat, cur_random);
                last_data = (e.op == OP_DRD);
            end
            OP_BOTH: begin
                fork
                    axi_read(1'b1, e.addr, f_data, f_resp, f_lat, f_rise);
                    axi_read(1'b0, e.addr2, d_data, d_resp, d_lat, d_rise);
                join
                check_data({e.name, "_fetch"}, ref_mem[ref_idx(e.addr)], f_data);
                check_data({e.name, "_data"}, ref_mem[ref_idx(e.addr2)], d_data);
                check_resp({e.name, "_fetch"}, 2'b00, f_resp);
                check_resp({e.name, "_data"}, 2'b00, d_resp);
                // fetch goes first when data had the last grant
                check_flag({e.name, "_fetch_first"}, last_data, f_rise < d_rise);
                last_data = (f_rise < d_rise);
            end
            default: ;
        endcase
    endtask

    task automatic add_entry(input op_t op, input mem_pkg::axi_addr_t addr,
                             input mem_pkg::axi_addr_t addr2, input mem_pkg::axi_data_t data,
                             input mem_pkg::axi_strb_t strb, input logic rnd,
                             input mem_pkg::wait_t wt, input int exp_lat, input string name);
        tbl.push_back('{op, addr, addr2, data, strb, rnd, wt, exp_lat, name});
    endtask

    task automatic build_table();
        add_entry(OP_CFG, 0, 0, 0, 0, 1'b0, 3'd0, -1, "cfg_fixed_w0");
        add_entry(OP_DWR, 32'h0, 0, 32'h1122_3344, 4'hf, 0, 0, -1, "wr_full_0");
        add_entry(OP_DWR, 32'h4, 0, 32'ha5a5_a5a5, 4'hf, 0, 0, -1, "wr_full_4");
        add_entry(OP_DWR, 32'h4, 0, 32'h00ff_00ff, 4'b0101, 0, 0, -1, "wr_part_4");
        add_entry(OP_DWR, 32'h1008, 0, 32'hcafe_f00d, 4'hf, 0, 0, -1, "wr_wrap_8");
        add_entry(OP_DWR, 32'hc, 0, 32'h0102_0304, 4'hf, 0, 0, -1, "wr_full_c");
        add_entry(OP_DRD, 32'h4, 0, 0, 0, 0, 0, 2, "rd_part_4");
        add_entry(OP_FRD, 32'h8, 0, 0, 0, 0, 0, 2, "fetch_wrap_8");
        add_entry(OP_FRD, 32'h0, 0, 0, 0, 0, 0, 2, "fetch_w0");
        add_entry(OP_CFG, 0, 0, 0, 0, 1'b0, 3'd3, -1, "cfg_fixed_w3");
        add_entry(OP_FRD, 32'hc, 0, 0, 0, 0, 0, 5, "fetch_w3");
        add_entry(OP_DWR, 32'hc, 0, 32'hffee_0000, 4'b1100, 0, 0, -1, "wr_part_c");
        add_entry(OP_CFG, 0, 0, 0, 0, 1'b0, 3'd7, -1, "cfg_fixed_w7");
        add_entry(OP_FRD, 32'hc, 0, 0, 0, 0, 0, 9, "fetch_w7");
        add_entry(OP_DRD, 32'h2004, 0, 0, 0, 0, 0, 9, "rd_wrap_4_w7");
        add_entry(OP_CFG, 0, 0, 0, 0, 1'b1, 3'd0, -1, "cfg_random");
        add_entry(OP_DWR, 32'h10, 0, 32'h5566_7788, 4'hf, 0, 0, -1, "rnd_wr_10");
        add_entry(OP_DWR, 32'h10, 0, 32'h0000_99aa, 4'b0011, 0, 0, -1, "rnd_wr_part_10");
        add_entry(OP_DRD, 32'h10, 0, 0, 0, 0, 0, 9, "rnd_rd_10");
        add_entry(OP_FRD, 32'h0, 0, 0, 0, 0, 0, 9, "rnd_fetch_0");
        add_entry(OP_DWR, 32'h3ffc, 0, 32'h7777_1111, 4'hf, 0, 0, -1, "rnd_wr_top");
        add_entry(OP_FRD, 32'hffc, 0, 0, 0, 0, 0, 9, "rnd_fetch_top");
        add_entry(OP_DRD, 32'h8, 0, 0, 0, 0, 0, 9, "rnd_rd_8");
        add_entry(OP_BOTH, 32'h0, 32'h4, 0, 0, 0, 0, -1, "both_rnd_a");
        add_entry(OP_FRD, 32'h4, 0, 0, 0, 0, 0, 9, "rnd_fetch_4");
        add_entry(OP_BOTH, 32'hc, 32'h10, 0, 0, 0, 0, -1, "both_rnd_b");
        add_entry(OP_DRD, 32'hc, 0, 0, 0, 0, 0, 9, "rnd_rd_c");
        add_entry(OP_BOTH, 32'h8, 32'hffc, 0, 0, 0, 0, -1, "both_rnd_c");
        add_entry(OP_CFG, 0, 0, 0, 0, 1'b0, 3'd0, -1, "cfg_fixed_back");
        add_entry(OP_FRD, 32'h10, 0, 0, 0, 0, 0, 2, "fetch_10_w0");
        add_entry(OP_BOTH, 32'h4, 32'h0, 0, 0, 0, 0, -1, "both_fixed_a");
        add_entry(OP_DRD, 32'h4, 0, 0, 0, 0, 0, 2, "rd_4_w0");
        add_entry(OP_BOTH, 32'h10, 32'h8, 0, 0, 0, 0, -1, "both_fixed_b");
    endtask

    initial begin
        wait (n_tests > 0);
        #((n_tests * (8 + 2 * MAX_BP) + RESET_CYC) * PERIOD);
        $display("watchdog expired, a transaction never completed");
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        rst_n      = 1'b0;
        f_araddr   = '0;
        f_arvalid  = 1'b0;
        f_rready   = 1'b0;
        d_araddr   = '0;
        d_arvalid  = 1'b0;
        d_rready   = 1'b0;
        d_awaddr   = '0;
        d_awvalid  = 1'b0;
        d_wdata    = '0;
        d_wstrb    = '0;
        d_wvalid   = 1'b0;
        d_bready   = 1'b0;
        cfg_we     = 1'b0;
        cfg_random = 1'b0;
        cfg_wait   = '0;
        build_table();
        n_tests = tbl.size();
        repeat (RESET_CYC - 1) @(posedge clk);
        @(negedge clk);
        check_flag("reset_f_arready", 1'b0, f_arready);
        check_flag("reset_d_arready", 1'b0, d_arready);
        check_flag("reset_d_awready", 1'b0, d_awready);
        check_flag("reset_d_wready", 1'b0, d_wready);
        check_flag("reset_f_rvalid", 1'b0, f_rvalid);
        check_flag("reset_d_rvalid", 1'b0, d_rvalid);
        check_flag("reset_d_bvalid", 1'b0, d_bvalid);
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        // nothing read yet, so rdata still shows the reset word
        check_data("reset_d_rdata", `MEM_RESET_DATA, d_rdata);
        check_data("reset_f_rdata", `MEM_RESET_DATA, f_rdata);
        foreach (tbl[i]) begin
            run_entry(tbl[i]);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_subsys.f ====
+incdir+.
mem_pkg.sv
sram_array.sv
sram_latency_ctrl.sv
sram_axil.sv
axil_arbiter.sv
mem_subsys.sv
tb_mem_subsys.sv
